// ==== logic/rename_pkg.sv ====
// Rename subsystem package with the sizes, tag types and per-lane structs

package rename_pkg;

  // ========================================
  // Sizes
  // ========================================
  localparam int ARCH_REGS  = 16;
  localparam int PHYS_REGS  = 32;
  // Rename and retire width, lane LANES-1 is the oldest
  localparam int LANES      = 2;
  localparam int AR_W       = 4;
  localparam int PR_W       = 5;
  // Tags not held by the architectural map
  localparam int FREE_DEPTH = PHYS_REGS - ARCH_REGS;
  // Ring index plus one wrap bit
  localparam int FREE_PTR_W = 5;

  // ========================================
  // Types
  // ========================================
  typedef logic [AR_W-1:0] ar_idx_t;
  typedef logic [PR_W-1:0] pr_tag_t;

  // One instruction presented for rename
  typedef struct packed {
    logic    dest_valid;
    ar_idx_t dest_ar;
    ar_idx_t src1_ar;
    ar_idx_t src2_ar;
    logic    valid;
  } rename_req_t;

  // Renamed operands of one lane
  typedef struct packed {
    pr_tag_t dest_pr;
    pr_tag_t src1_pr;
    logic    src1_ready;
    pr_tag_t src2_pr;
    logic    src2_ready;
  } rename_rsp_t;

  // Common data bus broadcast slot
  typedef struct packed {
    logic    valid;
    pr_tag_t tag;
  } cdb_t;

  // Commit of one instruction, told goes back to the free list
  typedef struct packed {
    logic    valid;
    ar_idx_t ar;
    pr_tag_t new_pr;
    pr_tag_t told;
  } retire_t;

endpackage

// ==== logic/free_list.sv ====
// Free list ring of physical tags with speculative and committed heads
`timescale 1ns/1ps

module free_list
  import rename_pkg::*;
(
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      recover,
  input  rename_req_t [LANES-1:0]   req,
  input  retire_t     [LANES-1:0]   retire,
  output pr_tag_t     [LANES-1:0]   alloc_pr,
  output logic                      stall
);

  // Ring storage and pointers, MSB of each pointer is the wrap bit
  pr_tag_t               ring [FREE_DEPTH];
  logic [FREE_PTR_W-1:0] spec_head;
  logic [FREE_PTR_W-1:0] commit_head;
  logic [FREE_PTR_W-1:0] tail;
  logic [FREE_PTR_W-1:0] free_count;

  // Per-lane ring positions for allocation and for retire pushes
  logic [FREE_PTR_W-1:0] alloc_ptr [LANES];
  logic [FREE_PTR_W-1:0] push_ptr  [LANES];
  logic [FREE_PTR_W-1:0] alloc_cnt;
  logic [FREE_PTR_W-1:0] push_cnt;
  logic                  alloc_fire;

  // ========================================
  // Allocation, oldest lane takes the head
  // ========================================
  always_comb begin
    alloc_cnt = '0;
    for (int l = LANES - 1; l >= 0; l--) begin
      alloc_ptr[l] = spec_head + alloc_cnt;
      alloc_pr[l]  = ring[alloc_ptr[l][FREE_PTR_W-2:0]];
      if (req[l].valid && req[l].dest_valid) begin
        alloc_cnt = alloc_cnt + 1'b1;
      end
    end
  end

  // Full list gives tail - head == FREE_DEPTH thanks to the wrap bit
  assign free_count = tail - spec_head;
  assign stall      = (free_count < alloc_cnt);
  // Recover cycle drops the group
  assign alloc_fire = !stall && !recover;

  // Retire pushes, oldest lane goes in first
  always_comb begin
    push_cnt = '0;
    for (int l = LANES - 1; l >= 0; l--) begin
      push_ptr[l] = tail + push_cnt;
      if (retire[l].valid) begin
        push_cnt = push_cnt + 1'b1;
      end
    end
  end

  // ========================================
  // Pointer state
  // ========================================
  always_ff @(posedge clock) begin
    if (reset) begin
      spec_head   <= '0;
      commit_head <= '0;
      tail        <= FREE_PTR_W'(FREE_DEPTH);
    end else begin
      tail        <= tail + push_cnt;
      // Every retiring lane consumed one tag when it was renamed
      commit_head <= commit_head + push_cnt;
      if (recover) begin
        spec_head <= commit_head;
      end else if (alloc_fire) begin
        spec_head <= spec_head + alloc_cnt;
      end
    end
  end

  // Ring starts holding every tag above the identity mapping
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < FREE_DEPTH; i++) begin
        ring[i] <= pr_tag_t'(ARCH_REGS + i);
      end
    end else begin
      for (int l = LANES - 1; l >= 0; l--) begin
        if (retire[l].valid) begin
          ring[push_ptr[l][FREE_PTR_W-2:0]] <= retire[l].told;
        end
      end
    end
  end

  // Retire must never push more tags than were handed out
  a_free_count_range: assert property (@(posedge clock) disable iff (reset)
    free_count <= FREE_PTR_W'(FREE_DEPTH));

  // Recovery and commit are never in the same cycle
  a_no_recover_retire: assert property (@(posedge clock) disable iff (reset)
    recover |-> (push_cnt == '0));

endmodule

// ==== logic/map_table.sv ====
// Speculative map table with readiness tracking, in-group bypass and registered Told
`timescale 1ns/1ps

module map_table
  import rename_pkg::*;
(
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          recover,
  input  logic                          stall,
  input  rename_req_t [LANES-1:0]       req,
  input  pr_tag_t     [LANES-1:0]       alloc_pr,
  input  cdb_t        [LANES-1:0]       cdb,
  input  pr_tag_t     [ARCH_REGS-1:0]   arch_map,
  output rename_rsp_t [LANES-1:0]       rsp,
  output pr_tag_t     [LANES-1:0]       told,
  output logic        [LANES-1:0]       told_valid
);

  // Live state mapping architectural index to physical tag
  pr_tag_t map_q   [ARCH_REGS];
  logic    ready_q [ARCH_REGS];

  // Image chain
  // Index LANES holds current state plus CDB and index 0 the whole group
  pr_tag_t map_img   [LANES+1][ARCH_REGS];
  logic    ready_img [LANES+1][ARCH_REGS];

  logic    [LANES-1:0] lane_ren;
  logic    [LANES-1:0] lane_fire;
  pr_tag_t [LANES-1:0] told_next;

  // True when any valid broadcast carries this tag
  function automatic logic cdb_hit(input pr_tag_t tag, input cdb_t [LANES-1:0] bus);
    logic hit;
    hit = 1'b0;
    for (int c = 0; c < LANES; c++) begin
      if (bus[c].valid && (bus[c].tag == tag)) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // Lanes that write a destination mapping
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      lane_ren[l] = req[l].valid && req[l].dest_valid;
    end
  end

  // Only a group that is neither stalled nor flushed takes effect
  assign lane_fire = lane_ren & {LANES{!stall && !recover}};

  // ========================================
  // Next-state image chain
  // ========================================
  always_comb begin
    // CDB hits first on the start-of-cycle mapping
    for (int r = 0; r < ARCH_REGS; r++) begin
      map_img[LANES][r]   = map_q[r];
      ready_img[LANES][r] = ready_q[r] || cdb_hit(map_q[r], cdb);
    end
    // Then each lane in program order, oldest first
    for (int l = LANES - 1; l >= 0; l--) begin
      for (int r = 0; r < ARCH_REGS; r++) begin
        map_img[l][r]   = map_img[l+1][r];
        ready_img[l][r] = ready_img[l+1][r];
      end
      if (lane_ren[l]) begin
        map_img[l][req[l].dest_ar] = alloc_pr[l];
        // Register 0 is renamed but always reads as ready
        if (req[l].dest_ar != '0) begin
          ready_img[l][req[l].dest_ar] = 1'b0;
        end
      end
    end
  end

  // ========================================
  // Operand lookup
  // ========================================
  // Each lane reads the image left by all older lanes
  always_comb begin
    for (int l = LANES - 1; l >= 0; l--) begin
      rsp[l].dest_pr    = alloc_pr[l];
      rsp[l].src1_pr    = map_img[l+1][req[l].src1_ar];
      rsp[l].src1_ready = ready_img[l+1][req[l].src1_ar];
      rsp[l].src2_pr    = map_img[l+1][req[l].src2_ar];
      rsp[l].src2_ready = ready_img[l+1][req[l].src2_ar];
      // An older lane with the same destination supplies the old mapping
      told_next[l]      = map_img[l+1][req[l].dest_ar];
    end
  end

  // ========================================
  // State registers
  // ========================================
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < ARCH_REGS; r++) begin
        map_q[r]   <= pr_tag_t'(r);
        ready_q[r] <= 1'b1;
      end
    end else if (recover) begin
      // Committed state has no pending producers
      for (int r = 0; r < ARCH_REGS; r++) begin
        map_q[r]   <= arch_map[r];
        ready_q[r] <= 1'b1;
      end
    end else begin
      // Stalled group is dropped but CDB wakeups still land
      for (int r = 0; r < ARCH_REGS; r++) begin
        map_q[r]   <= stall ? map_img[LANES][r] : map_img[0][r];
        ready_q[r] <= stall ? ready_img[LANES][r] : ready_img[0][r];
      end
    end
  end

  // Told is loaded only for lanes that rename, and held otherwise
  always_ff @(posedge clock) begin
    if (reset) begin
      told       <= '0;
      told_valid <= '0;
    end else begin
      told_valid <= lane_fire;
      for (int l = 0; l < LANES; l++) begin
        if (lane_fire[l]) begin
          told[l] <= told_next[l];
        end
      end
    end
  end

  // A destination never receives the tag it replaces
  for (genvar g = 0; g < LANES; g++) begin : g_told_chk
    a_new_tag_differs: assert property (@(posedge clock) disable iff (reset)
      lane_fire[g] |-> (alloc_pr[g] != told_next[g]));
  end

endmodule

// ==== logic/arch_map_table.sv ====
// Architectural map table holding the committed register mapping
`timescale 1ns/1ps

module arch_map_table
  import rename_pkg::*;
(
  input  logic                          clock,
  input  logic                          reset,
  input  retire_t     [LANES-1:0]       retire,
  output pr_tag_t     [ARCH_REGS-1:0]   arch_map
);

  // Committed image after this cycle's retires
  pr_tag_t [ARCH_REGS-1:0] arch_next;

  // ========================================
  // Commit update
  // ========================================
  // Oldest lane first, so the younger lane wins on a shared register
  always_comb begin
    arch_next = arch_map;
    for (int l = LANES - 1; l >= 0; l--) begin
      if (retire[l].valid) begin
        arch_next[retire[l].ar] = retire[l].new_pr;
      end
    end
  end

  // Identity mapping out of reset
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < ARCH_REGS; r++) begin
        arch_map[r] <= pr_tag_t'(r);
      end
    end else begin
      arch_map <= arch_next;
    end
  end

  // Oldest retiring lane frees exactly the committed tag it replaces
  a_told_committed: assert property (@(posedge clock) disable iff (reset)
    retire[LANES-1].valid |->
      (retire[LANES-1].told == arch_map[retire[LANES-1].ar]));

endmodule

// ==== logic/rename_unit.sv ====
// Register rename top level joining free list, speculative map and committed map
`timescale 1ns/1ps

module rename_unit
  import rename_pkg::*;
(
  input  logic                          clock,
  input  logic                          reset,

  // Dispatch side
  input  rename_req_t [LANES-1:0]       req,
  output rename_rsp_t [LANES-1:0]       rsp,
  output logic                          stall,

  // Wakeup broadcasts
  input  cdb_t        [LANES-1:0]       cdb,

  // Commit side
  input  retire_t     [LANES-1:0]       retire,
  input  logic                          recover,

  // Old mapping of each renamed destination, one cycle late
  output pr_tag_t     [LANES-1:0]       told,
  output logic        [LANES-1:0]       told_valid
);

  // ========================================
  // Internal wiring
  // ========================================
  pr_tag_t [LANES-1:0]     alloc_pr;
  pr_tag_t [ARCH_REGS-1:0] arch_map;

  // Tag allocation and reclaim
  free_list free_list_inst (
    .clock    (clock),
    .reset    (reset),
    .recover  (recover),
    .req      (req),
    .retire   (retire),
    .alloc_pr (alloc_pr),
    .stall    (stall)
  );

  // Speculative rename
  map_table map_table_inst (
    .clock      (clock),
    .reset      (reset),
    .recover    (recover),
    .stall      (stall),
    .req        (req),
    .alloc_pr   (alloc_pr),
    .cdb        (cdb),
    .arch_map   (arch_map),
    .rsp        (rsp),
    .told       (told),
    .told_valid (told_valid)
  );

  // Committed mapping, recovery source
  arch_map_table arch_map_table_inst (
    .clock    (clock),
    .reset    (reset),
    .retire   (retire),
    .arch_map (arch_map)
  );

endmodule

// ==== bench/rename_checker.sv ====
// Rename checker with a reference model of both maps and the free list, compared every cycle
`timescale 1ns/1ps

module rename_checker
  import rename_pkg::*;
(
  input  logic                      clock,
  input  logic                      reset,
  input  rename_req_t [LANES-1:0]   req,
  input  cdb_t        [LANES-1:0]   cdb,
  input  retire_t     [LANES-1:0]   retire,
  input  logic                      recover,
  input  rename_rsp_t [LANES-1:0]   rsp,
  input  logic                      stall,
  input  pr_tag_t     [LANES-1:0]   told,
  input  logic        [LANES-1:0]   told_valid,
  output int                        error_count
);

  // Model state
  pr_tag_t          map  [ARCH_REGS];
  pr_tag_t          arch [ARCH_REGS];
  logic             rdy  [ARCH_REGS];
  pr_tag_t          ring [FREE_DEPTH];
  int               spec_head;
  int               commit_head;
  int               tail;
  pr_tag_t          exp_told [LANES];
  logic [LANES-1:0] exp_told_valid;

  initial error_count = 0;

  task automatic mismatch(input string name, input int exp, input int act);
    $display("FAIL time=%0t %s expected=%0d actual=%0d", $time, name, exp, act);
    error_count++;
  endtask

  // ========================================
  // Compare, then step the model
  // ========================================
  // Inputs change on the rising edge, so the falling edge sees settled outputs
  always @(negedge clock) begin
    pr_tag_t          wmap [ARCH_REGS];
    logic             wrdy [ARCH_REGS];
    logic             crdy [ARCH_REGS];
    pr_tag_t          told_n [LANES];
    logic [LANES-1:0] fire;
    logic             exp_stall;
    pr_tag_t          dpr;
    int               need;
    int               k;
    if (reset) begin
      for (int r = 0; r < ARCH_REGS; r++) begin
        map[r]  = pr_tag_t'(r);
        arch[r] = pr_tag_t'(r);
        rdy[r]  = 1'b1;
      end
      for (int i = 0; i < FREE_DEPTH; i++) begin
        ring[i] = pr_tag_t'(ARCH_REGS + i);
      end
      spec_head      = 0;
      commit_head    = 0;
      tail           = FREE_DEPTH;
      exp_told_valid = '0;
    end else begin
      // Wakeups land before any lane reads
      for (int r = 0; r < ARCH_REGS; r++) begin
        crdy[r] = rdy[r];
        for (int c = 0; c < LANES; c++) begin
          if (cdb[c].valid && cdb[c].tag == map[r]) crdy[r] = 1'b1;
        end
        wmap[r] = map[r];
        wrdy[r] = crdy[r];
      end
      need = 0;
      for (int l = 0; l < LANES; l++) begin
        if (req[l].valid && req[l].dest_valid) need++;
      end
      exp_stall = (tail - spec_head) < need;
      if (stall !== exp_stall) mismatch("stall", exp_stall, stall);
      // Lanes in program order, the oldest is the highest index
      k    = 0;
      fire = '0;
      for (int l = LANES - 1; l >= 0; l--) begin
        if (req[l].valid) begin
          if (rsp[l].src1_pr !== wmap[req[l].src1_ar])
            mismatch($sformatf("rsp[%0d].src1_pr", l), wmap[req[l].src1_ar], rsp[l].src1_pr);
          if (rsp[l].src1_ready !== wrdy[req[l].src1_ar])
            mismatch($sformatf("rsp[%0d].src1_ready", l), wrdy[req[l].src1_ar],
                     rsp[l].src1_ready);
          if (rsp[l].src2_pr !== wmap[req[l].src2_ar])
            mismatch($sformatf("rsp[%0d].src2_pr", l), wmap[req[l].src2_ar], rsp[l].src2_pr);
          if (rsp[l].src2_ready !== wrdy[req[l].src2_ar])
            mismatch($sformatf("rsp[%0d].src2_ready", l), wrdy[req[l].src2_ar],
                     rsp[l].src2_ready);
          if (req[l].dest_valid) begin
            dpr = ring[(spec_head + k) % FREE_DEPTH];
            if (!exp_stall && rsp[l].dest_pr !== dpr)
              mismatch($sformatf("rsp[%0d].dest_pr", l), dpr, rsp[l].dest_pr);
            told_n[l]            = wmap[req[l].dest_ar];
            wmap[req[l].dest_ar] = dpr;
            if (req[l].dest_ar != '0) wrdy[req[l].dest_ar] = 1'b0;
            fire[l] = !exp_stall && !recover;
            k++;
          end
        end
      end
      // Told from the previous cycle's group
      for (int l = 0; l < LANES; l++) begin
        if (told_valid[l] !== exp_told_valid[l])
          mismatch($sformatf("told_valid[%0d]", l), exp_told_valid[l], told_valid[l]);
        else if (exp_told_valid[l] && told[l] !== exp_told[l])
          mismatch($sformatf("told[%0d]", l), exp_told[l], told[l]);
      end
      // Next state
      if (recover) begin
        for (int r = 0; r < ARCH_REGS; r++) begin
          map[r] = arch[r];
          rdy[r] = 1'b1;
        end
        spec_head = commit_head;
      end else if (exp_stall) begin
        for (int r = 0; r < ARCH_REGS; r++) rdy[r] = crdy[r];
      end else begin
        for (int r = 0; r < ARCH_REGS; r++) begin
          map[r] = wmap[r];
          rdy[r] = wrdy[r];
        end
        spec_head = spec_head + need;
      end
      exp_told_valid = fire;
      for (int l = 0; l < LANES; l++) begin
        if (fire[l]) exp_told[l] = told_n[l];
      end
      // Commit, oldest lane first
      for (int l = LANES - 1; l >= 0; l--) begin
        if (retire[l].valid) begin
          arch[retire[l].ar]      = retire[l].new_pr;
          ring[tail % FREE_DEPTH] = retire[l].told;
          tail++;
          commit_head++;
        end
      end
    end
  end

endmodule

// ==== bench/rename_unit_tb.sv ====
// Rename unit testbench with a stimulus table acting as dispatch, CDB and retire
`timescale 1ns/1ps

module rename_unit_tb
  import rename_pkg::*;
();

  localparam int ROWS     = 40;
  localparam int DIRECTED = 18;

  // One cycle of stimulus plus an optional directed check
  typedef struct {
    rename_req_t [LANES-1:0] req;
    cdb_t        [LANES-1:0] cdb;
    int                      n_retire;
    logic                    recover;
    logic                    chk;
    int                      chk_lane;
    pr_tag_t                 exp_pr;
    logic                    exp_rdy;
    logic                    chk_stall;
  } row_t;

  logic                    clock;
  logic                    reset;
  rename_req_t [LANES-1:0] req;
  cdb_t        [LANES-1:0] cdb;
  retire_t     [LANES-1:0] retire;
  logic                    recover;
  rename_rsp_t [LANES-1:0] rsp;
  logic                    stall;
  pr_tag_t     [LANES-1:0] told;
  logic        [LANES-1:0] told_valid;
  int                      check_errors;
  int                      table_errors;
  int                      seed;

  row_t    rows [ROWS];
  // Renamed but not yet retired in program order
  retire_t pending [$];
  pr_tag_t spec_shadow [ARCH_REGS];
  pr_tag_t arch_shadow [ARCH_REGS];

  always #20 clock = ~clock;

  rename_unit rename_unit_inst (
    .clock      (clock),
    .reset      (reset),
    .req        (req),
    .rsp        (rsp),
    .stall      (stall),
    .cdb        (cdb),
    .retire     (retire),
    .recover    (recover),
    .told       (told),
    .told_valid (told_valid)
  );

  rename_checker checker_inst (
    .clock       (clock),
    .reset       (reset),
    .req         (req),
    .cdb         (cdb),
    .retire      (retire),
    .recover     (recover),
    .rsp         (rsp),
    .stall       (stall),
    .told        (told),
    .told_valid  (told_valid),
    .error_count (check_errors)
  );

  function automatic rename_req_t make_req(input logic dv, input int d, input int s1,
                                           input int s2);
    make_req = '{dest_valid: dv, dest_ar: ar_idx_t'(d), src1_ar: ar_idx_t'(s1),
                 src2_ar: ar_idx_t'(s2), valid: 1'b1};
  endfunction

  task automatic set_check(input int i, input int lane, input int pr, input logic rdy);
    rows[i].chk      = 1'b1;
    rows[i].chk_lane = lane;
    rows[i].exp_pr   = pr_tag_t'(pr);
    rows[i].exp_rdy  = rdy;
  endtask

  // ========================================
  // Stimulus table
  // ========================================
  task automatic build_table();
    for (int i = 0; i < ROWS; i++) rows[i] = '{default: '0};
    // Identity after reset
    rows[0].req[1] = make_req(1'b0, 0, 3, 5);
    set_check(0, 1, 3, 1'b1);
    // Younger lane sees the older lane's new tag
    rows[1].req[1] = make_req(1'b1, 1, 2, 3);
    rows[1].req[0] = make_req(1'b1, 2, 1, 4);
    set_check(1, 0, 16, 1'b0);
    // Broadcast wakes the reader in the same cycle
    rows[2].req[1] = make_req(1'b0, 0, 1, 2);
    rows[2].cdb[0] = '{valid: 1'b1, tag: pr_tag_t'(16)};
    set_check(2, 1, 16, 1'b1);
    // Same destination in both lanes
    rows[3].req[1] = make_req(1'b1, 3, 1, 1);
    rows[3].req[0] = make_req(1'b1, 3, 3, 2);
    set_check(3, 0, 18, 1'b0);
    rows[4].req[1] = make_req(1'b0, 0, 1, 0);
    set_check(4, 1, 16, 1'b1);
    rows[5].n_retire = 2;
    rows[6].recover  = 1'b1;
    // Unretired r3 rolls back to identity
    rows[7].req[1] = make_req(1'b1, 4, 3, 1);
    rows[7].req[0] = make_req(1'b1, 5, 2, 4);
    set_check(7, 1, 3, 1'b1);
    rows[8].req[1] = make_req(1'b0, 0, 1, 2);
    set_check(8, 1, 16, 1'b1);
    // Drain the list without retiring
    for (int i = 9; i < 16; i++) begin
      rows[i].req[1] = make_req(1'b1, 6, i % 16, 7);
      rows[i].req[0] = make_req(1'b1, 7, 6, 1);
    end
    rows[16].req[1]    = make_req(1'b1, 8, 6, 7);
    rows[16].req[0]    = make_req(1'b1, 9, 8, 2);
    rows[16].n_retire  = 1;
    rows[16].chk_stall = 1'b1;
    rows[17].req[1]    = make_req(1'b0, 0, 8, 9);
    // Random tail
    for (int i = DIRECTED; i < ROWS; i++) begin
      for (int l = 0; l < LANES; l++) begin
        rows[i].req[l] = make_req($random(seed) & 1, $random(seed) & 15,
                                  $random(seed) & 15, $random(seed) & 15);
        rows[i].req[l].valid = ($random(seed) & 3) != 0;
        rows[i].cdb[l] = '{valid: $random(seed) & 1,
                           tag: pr_tag_t'(ARCH_REGS + ($random(seed) & 15))};
      end
      rows[i].recover  = ($random(seed) & 15) == 0;
      rows[i].n_retire = rows[i].recover ? 0 : ($random(seed) & 3);
    end
  endtask

  // Retires pop the oldest pending renames into the highest lanes
  task automatic drive_row(input row_t row, input logic first);
    retire_t [LANES-1:0] ret;
    int                  cnt;
    ret = '0;
    cnt = row.n_retire;
    // Repeats of a stalled group retire at least one entry to free a tag
    if (!first && cnt == 0) cnt = 1;
    if (cnt > LANES) cnt = LANES;
    if (cnt > pending.size()) cnt = pending.size();
    for (int j = 0; j < cnt; j++) begin
      ret[LANES-1-j] = pending.pop_front();
      arch_shadow[ret[LANES-1-j].ar] = ret[LANES-1-j].new_pr;
    end
    if (row.recover) begin
      spec_shadow = arch_shadow;
      pending.delete();
    end
    req     <= row.req;
    cdb     <= row.cdb;
    retire  <= ret;
    recover <= row.recover;
  endtask

  // Accepted group enters the pending queue with the oldest lane first
  task automatic record_renames();
    retire_t e;
    for (int l = LANES - 1; l >= 0; l--) begin
      if (req[l].valid && req[l].dest_valid) begin
        e = '{valid: 1'b1, ar: req[l].dest_ar, new_pr: rsp[l].dest_pr,
              told: spec_shadow[req[l].dest_ar]};
        spec_shadow[req[l].dest_ar] = rsp[l].dest_pr;
        pending.push_back(e);
      end
    end
  endtask

  task automatic check_row(input row_t row, input logic first);
    if (row.chk && rsp[row.chk_lane].src1_pr !== row.exp_pr) begin
      $display("FAIL time=%0t rsp[%0d].src1_pr expected=%0d actual=%0d", $time,
               row.chk_lane, row.exp_pr, rsp[row.chk_lane].src1_pr);
      table_errors++;
    end
    if (row.chk && rsp[row.chk_lane].src1_ready !== row.exp_rdy) begin
      $display("FAIL time=%0t rsp[%0d].src1_ready expected=%0d actual=%0d", $time,
               row.chk_lane, row.exp_rdy, rsp[row.chk_lane].src1_ready);
      table_errors++;
    end
    if (row.chk_stall && first && stall !== 1'b1) begin
      $display("FAIL time=%0t stall expected=1 actual=%0d", $time, stall);
      table_errors++;
    end
  endtask

  // Watchdog sized from the table length
  initial begin
    #((ROWS + 20) * 40 * 2);
    $display("Timeout: the stimulus table did not finish in the allowed time");
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    logic first;
    clock        = 1'b0;
    reset        = 1'b1;
    req          = '0;
    cdb          = '0;
    retire       = '0;
    recover      = 1'b0;
    table_errors = 0;
    seed         = 93;
    for (int r = 0; r < ARCH_REGS; r++) begin
      spec_shadow[r] = pr_tag_t'(r);
      arch_shadow[r] = pr_tag_t'(r);
    end
    build_table();
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    for (int i = 0; i < ROWS; i++) begin
      first = 1'b1;
      do begin
        @(posedge clock);
        drive_row(rows[i], first);
        @(negedge clock);
        check_row(rows[i], first);
        if (!stall && !recover) record_renames();
        first = 1'b0;
      end while (stall && !rows[i].recover);
    end
    @(posedge clock);
    req     <= '0;
    cdb     <= '0;
    retire  <= '0;
    recover <= 1'b0;
    repeat (2) @(negedge clock);
    @(posedge clock);
    $display("Errors: checker=%0d table=%0d", check_errors, table_errors);
    if (check_errors == 0 && table_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
logic/rename_pkg.sv
logic/free_list.sv
logic/map_table.sv
logic/arch_map_table.sv
logic/rename_unit.sv
bench/rename_checker.sv
bench/rename_unit_tb.sv

// ==== Bender.yml ====
package:
  name: rename_unit

sources:
  # Package first, then the stages, then the top level
  - logic/rename_pkg.sv
  - logic/free_list.sv
  - logic/map_table.sv
  - logic/arch_map_table.sv
  - logic/rename_unit.sv
  - target: test
    files:
      - bench/rename_checker.sv
      - bench/rename_unit_tb.sv
